// File: sim/mem_cases.txt
# op addr data mask expected (hex) ; load with mask 1 reads mtime low and checks its advance
# dual mask 0 fetches addr and loads addr+4 (data = load value) ; wait data = cycles, expected = irq
store 00000000 12345678 f 00000000
store 00000004 a5a5a5a5 f 00000000
store 00000000 cafef00d 5 00000000
load  00000000 00000000 0 12fe560d
store 00000100 00000013 f 00000000
store 00000104 00100093 f 00000000
fetch 00000100 00000000 0 00000013
fetch 00000104 00000000 0 00100093
dual  00000000 a5a5a5a5 0 12fe560d
dual  00000100 ffff0000 c 00000013
load  00000100 00000000 0 ffff0013
load  00010000 00000000 0 ffffffff
wait  00000000 00000002 0 00000000
load  00008000 00000000 1 00000000
wait  00000000 00000005 0 00000000
load  00008000 00000000 1 00000000
store 00008008 00000000 f 00000000
store 0000800c 00000000 f 00000000
wait  00000000 00000002 0 00000001
load  00008008 00000000 0 00000000
store 00008008 ffffffff f 00000000
store 0000800c ffffffff f 00000000
wait  00000000 00000002 0 00000000
load  0000800c 00000000 0 ffffffff
fetch 00000000 00000000 0 12fe560d

// File: sources.f
hw/mem_pkg.sv
hw/mem_port_arbiter.sv
hw/mem_map_ctrl.sv
hw/data_ram.sv
hw/machine_timer.sv
hw/mem_subsystem_top.sv
sim/tb_clock_gen.sv
sim/mem_subsystem_tb.sv

// File: sim/mem_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_tb;

    import mem_pkg::*;

    localparam int clk_period  = 40;
    localparam int drive_delay = 2;
    localparam int ram_words   = 2048;
    localparam case_file       = "sim/mem_cases.txt";

    logic              clk;
    logic              rst_n;
    logic              inst_start;
    logic [xlen-1:0]   i_addr;
    logic              inst_ready;
    logic [xlen-1:0]   inst;
    logic              inst_valid;
    logic              d_cmd_start;
    logic              d_cmd_write;
    logic              d_cmd_ready;
    logic [xlen-1:0]   d_addr;
    logic [xlen-1:0]   wdata;
    logic [mask_w-1:0] wmask;
    logic [xlen-1:0]   rdata;
    logic              rdata_valid;
    logic              timer_irq;

    logic [63:0]       op_q [$];
    logic [xlen-1:0]   addr_q [$];
    logic [xlen-1:0]   data_q [$];
    logic [mask_w-1:0] mask_q [$];
    logic [xlen-1:0]   exp_q [$];

    logic [xlen-1:0]   known_addr [$]; // stored words seen so far
    logic [xlen-1:0]   known_val [$];

    logic [xlen-1:0]   cycle_cnt;
    logic [xlen-1:0]   last_mtime;
    logic [xlen-1:0]   last_acc;
    logic              have_mtime;
    int                n_cases = 0;

    tb_clock_gen #(
        .period (clk_period)
    ) u_tb_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mem_subsystem_top #(
        .RAM_WORDS (ram_words)
    ) u_mem_subsystem_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .wmask       (wmask),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .timer_irq   (timer_irq)
    );

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_eq(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic expect_pulse(input logic sig, input string msg);
        if (sig !== 1'b1) begin
            fail_plain(msg);
        end
    endtask

    task automatic expect_quiet(input logic sig, input string msg);
        if (sig !== 1'b0) begin
            fail_plain(msg);
        end
    endtask

    function automatic int find_word(input logic [xlen-1:0] addr);
        int idx;
        idx = -1;
        for (int i = 0; i < known_addr.size(); i++) begin
            if (known_addr[i] == {addr[xlen-1:2], 2'b00}) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // unwritten words and unmapped space read as all ones
    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] addr);
        int idx;
        idx = find_word(addr);
        if (idx < 0) begin
            return '1;
        end
        return known_val[idx];
    endfunction

    task automatic record_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                                input logic [mask_w-1:0] mask);
        logic [xlen-1:0] merged;
        int idx;
        idx    = find_word(addr);
        merged = expected_word(addr);
        for (int lane = 0; lane < mask_w; lane++) begin
            if (mask[lane]) begin
                merged[8*lane +: 8] = data[8*lane +: 8];
            end
        end
        if (idx < 0) begin
            known_addr.push_back({addr[xlen-1:2], 2'b00});
            known_val.push_back(merged);
        end else begin
            known_val[idx] = merged;
        end
    endtask

    task automatic read_cases();
        int fd;
        int n;
        logic [63:0] tok;
        logic [xlen-1:0] a;
        logic [xlen-1:0] d;
        logic [xlen-1:0] e;
        logic [mask_w-1:0] m;
        logic [8*256-1:0] rest;
        logic more;
        fd = $fopen(case_file, "r");
        if (fd == 0) begin
            fail_plain("could not open the case file sim/mem_cases.txt");
        end
        more = 1'b1;
        while (more) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                more = 1'b0;
            end else if (tok == "#") begin
                n = $fgets(rest, fd); // comment line
            end else begin
                n = $fscanf(fd, "%h %h %h %h", a, d, m, e);
                if (n != 4) begin
                    fail_plain("a line of the case file has fewer than five columns");
                end
                op_q.push_back(tok);
                addr_q.push_back(a);
                data_q.push_back(d);
                mask_q.push_back(m);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // holds the command until both ports are ready
    task automatic wait_idle_ports();
        while (!(inst_ready && d_cmd_ready)) begin
            @(posedge clk);
            #drive_delay;
            @(negedge clk);
        end
    endtask

    task automatic run_fetch(input logic [xlen-1:0] addr, input logic [xlen-1:0] exp);
        check_eq(exp, expected_word(addr), "case file fetch value against model");
        @(posedge clk);
        #drive_delay;
        inst_start = 1'b1;
        i_addr     = addr;
        @(negedge clk);
        wait_idle_ports();
        @(posedge clk);
        #drive_delay;
        inst_start = 1'b0;
        @(negedge clk);
        expect_quiet(rdata_valid, "rdata_valid pulsed during a fetch");
        @(negedge clk);
        expect_pulse(inst_valid, "inst_valid missing two cycles after the fetch was accepted");
        expect_quiet(rdata_valid, "rdata_valid pulsed together with inst_valid");
        check_eq(inst, exp, "fetch data on inst");
    endtask

    task automatic run_load(input logic [xlen-1:0] addr, input logic [xlen-1:0] exp,
                            input logic is_mtime);
        logic [xlen-1:0] acc;
        if (!is_mtime) begin
            check_eq(exp, expected_word(addr), "case file load value against model");
        end
        @(posedge clk);
        #drive_delay;
        d_cmd_start = 1'b1;
        d_cmd_write = 1'b0;
        d_addr      = addr;
        @(negedge clk);
        wait_idle_ports();
        acc = cycle_cnt;
        @(posedge clk);
        #drive_delay;
        d_cmd_start = 1'b0;
        @(negedge clk);
        expect_quiet(rdata_valid | inst_valid, "a valid pulsed one cycle after a load");
        @(negedge clk);
        expect_pulse(rdata_valid, "rdata_valid missing two cycles after the load was accepted");
        expect_quiet(inst_valid, "inst_valid pulsed during a load");
        if (!is_mtime) begin
            check_eq(rdata, exp, "load data on rdata");
        end else begin
            if (have_mtime) begin
                check_eq(rdata - last_mtime, acc - last_acc, "mtime advance between reads");
            end
            last_mtime = rdata;
            last_acc   = acc;
            have_mtime = 1'b1;
        end
    endtask

    task automatic run_store(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                             input logic [mask_w-1:0] mask);
        @(posedge clk);
        #drive_delay;
        d_cmd_start = 1'b1;
        d_cmd_write = 1'b1;
        d_addr      = addr;
        wdata       = data;
        wmask       = mask;
        @(negedge clk);
        wait_idle_ports();
        @(posedge clk);
        #drive_delay;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        @(negedge clk);
        if (!(inst_ready && d_cmd_ready)) begin
            fail_plain("ports were not ready on the cycle after a write");
        end
        expect_quiet(rdata_valid | inst_valid, "a valid pulsed after a write");
        record_store(addr, data, mask);
    endtask

    // mask zero loads addr+4 next to the fetch, else the store goes to addr
    task automatic run_dual(input logic [xlen-1:0] addr, input logic [xlen-1:0] data,
                            input logic [mask_w-1:0] mask, input logic [xlen-1:0] exp);
        check_eq(exp, expected_word(addr), "case file fetch value against model");
        if (mask == '0) begin
            check_eq(data, expected_word(addr + 4), "case file load value against model");
        end
        @(posedge clk);
        #drive_delay;
        inst_start  = 1'b1;
        i_addr      = addr;
        d_cmd_start = 1'b1;
        d_cmd_write = (mask != '0);
        d_addr      = (mask == '0) ? addr + 4 : addr;
        wdata       = data;
        wmask       = mask;
        @(negedge clk);
        wait_idle_ports();
        @(posedge clk);
        #drive_delay;
        inst_start  = 1'b0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        @(negedge clk);
        expect_quiet(rdata_valid | inst_valid, "a valid pulsed one cycle after a dual command");
        @(negedge clk);
        expect_pulse(inst_valid, "inst_valid missing two cycles after the dual command");
        expect_quiet(rdata_valid, "rdata_valid pulsed together with inst_valid");
        check_eq(inst, exp, "dual fetch data on inst");
        @(negedge clk);
        if (mask == '0) begin
            expect_quiet(rdata_valid | inst_valid, "a valid pulsed right after inst_valid");
            @(negedge clk);
            expect_pulse(rdata_valid, "rdata_valid missing two cycles after inst_valid");
            expect_quiet(inst_valid, "inst_valid pulsed with the queued load data");
            check_eq(rdata, data, "queued load data on rdata");
        end else begin
            if (!(inst_ready && d_cmd_ready)) begin
                fail_plain("ports were not ready on the cycle after inst_valid");
            end
            record_store(addr, data, mask);
        end
    endtask

    task automatic run_wait(input logic [xlen-1:0] n, input logic [xlen-1:0] irq_exp);
        repeat (n) @(negedge clk);
        check_eq(timer_irq, irq_exp, "timer_irq after wait");
    endtask

    initial begin
        inst_start  = 1'b0;
        i_addr      = '0;
        d_cmd_start = 1'b0;
        d_cmd_write = 1'b0;
        d_addr      = '0;
        wdata       = '0;
        wmask       = '0;
        have_mtime  = 1'b0;
        last_mtime  = '0;
        last_acc    = '0;
        read_cases();
        if (op_q.size() == 0) begin
            fail_plain("the case file holds no operations");
        end
        n_cases = op_q.size();
        wait (rst_n === 1'b1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq(timer_irq, 0, "timer_irq after reset");
        check_eq(inst_ready && d_cmd_ready, 1, "port ready after reset");
        check_eq(inst_valid | rdata_valid, 0, "valid after reset");
        for (int i = 0; i < n_cases; i++) begin
            case (op_q[i])
                "fetch": run_fetch(addr_q[i], exp_q[i]);
                "load":  run_load(addr_q[i], exp_q[i], mask_q[i] != '0);
                "store": run_store(addr_q[i], data_q[i], mask_q[i]);
                "dual":  run_dual(addr_q[i], data_q[i], mask_q[i], exp_q[i]);
                "wait":  run_wait(data_q[i], exp_q[i]);
                default: fail_plain("unknown opcode in the case file");
            endcase
        end
        repeat (2) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

    // forty cycles per case line plus margin
    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 40 + 100) @(posedge clk);
        fail_plain("watchdog timeout, the case list did not finish in time");
    end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int period = 40
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset held over two rising edges, released off the edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #(period / 8);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/mem_subsystem_top.sv
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          inst_start,
    output logic                         inst_ready,
    input  wire  [mem_pkg::xlen-1:0]     i_addr,
    output logic [mem_pkg::xlen-1:0]     inst,
    output logic                         inst_valid,

    input  wire                          d_cmd_start,
    input  wire                          d_cmd_write,
    output logic                         d_cmd_ready,
    input  wire  [mem_pkg::xlen-1:0]     d_addr,
    input  wire  [mem_pkg::xlen-1:0]     wdata,
    input  wire  [mem_pkg::mask_w-1:0]   wmask,
    output logic [mem_pkg::xlen-1:0]     rdata,
    output logic                         rdata_valid,

    output logic                         timer_irq
);

    import mem_pkg::*;

    logic                         mem_cmd_start;
    logic                         mem_cmd_write;
    logic                         mem_cmd_ready;
    logic [xlen-1:0]              mem_addr;
    logic [xlen-1:0]              mem_wdata;
    logic [mask_w-1:0]            mem_wmask;
    logic [xlen-1:0]              mem_rdata;
    logic                         mem_rdata_valid;

    logic                         ram_en;
    logic                         ram_we;
    logic [$clog2(RAM_WORDS)-1:0] ram_addr;
    logic [xlen-1:0]              ram_wdata;
    logic [mask_w-1:0]            ram_mask;
    logic [xlen-1:0]              ram_rdata;

    logic                         tmr_we;
    logic [1:0]                   tmr_sel;
    logic [xlen-1:0]              tmr_wdata;
    logic [mask_w-1:0]            tmr_mask;
    logic [xlen-1:0]              tmr_rdata;

    mem_port_arbiter u_mem_port_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_start      (inst_start),
        .inst_ready      (inst_ready),
        .i_addr          (i_addr),
        .inst            (inst),
        .inst_valid      (inst_valid),
        .d_cmd_start     (d_cmd_start),
        .d_cmd_write     (d_cmd_write),
        .d_cmd_ready     (d_cmd_ready),
        .d_addr          (d_addr),
        .wdata           (wdata),
        .wmask           (wmask),
        .rdata           (rdata),
        .rdata_valid     (rdata_valid),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid)
    );

    mem_map_ctrl #(
        .RAM_WORDS (RAM_WORDS)
    ) u_mem_map_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_cmd_start   (mem_cmd_start),
        .mem_cmd_write   (mem_cmd_write),
        .mem_cmd_ready   (mem_cmd_ready),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_rdata       (mem_rdata),
        .mem_rdata_valid (mem_rdata_valid),
        .ram_en          (ram_en),
        .ram_we          (ram_we),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_mask        (ram_mask),
        .ram_rdata       (ram_rdata),
        .tmr_we          (tmr_we),
        .tmr_sel         (tmr_sel),
        .tmr_wdata       (tmr_wdata),
        .tmr_mask        (tmr_mask),
        .tmr_rdata       (tmr_rdata)
    );

    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .mask  (ram_mask),
        .rdata (ram_rdata)
    );

    machine_timer u_machine_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (tmr_we),
        .sel       (tmr_sel),
        .wdata     (tmr_wdata),
        .mask      (tmr_mask),
        .rdata     (tmr_rdata),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// File: hw/machine_timer.sv
`timescale 1ns/10ps
`default_nettype none

module machine_timer (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         we,
    input  wire  [1:0]                  sel,
    input  wire  [mem_pkg::xlen-1:0]    wdata,
    input  wire  [mem_pkg::mask_w-1:0]  mask,
    output logic [mem_pkg::xlen-1:0]    rdata,
    output logic                        timer_irq
);

    import mem_pkg::*;

    localparam logic [1:0] sel_time_lo = mtime_lo_off[3:2];
    localparam logic [1:0] sel_time_hi = mtime_hi_off[3:2];
    localparam logic [1:0] sel_cmp_lo  = mtimecmp_lo_off[3:2];
    localparam logic [1:0] sel_cmp_hi  = mtimecmp_hi_off[3:2];

    logic [2*xlen-1:0] mtime;
    logic [2*xlen-1:0] mtimecmp;
    logic [2*xlen-1:0] mtime_inc;

    assign mtime_inc = mtime + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (we && sel == sel_time_lo) begin
            mtime <= {mtime_inc[2*xlen-1:xlen], merge_bytes(mtime[xlen-1:0], wdata, mask)};
        end else if (we && sel == sel_time_hi) begin
            mtime <= {merge_bytes(mtime[2*xlen-1:xlen], wdata, mask), mtime_inc[xlen-1:0]};
        end else begin
            mtime <= mtime_inc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1; // irq off until software sets a compare
        end else if (we && sel == sel_cmp_lo) begin
            mtimecmp[xlen-1:0] <= merge_bytes(mtimecmp[xlen-1:0], wdata, mask);
        end else if (we && sel == sel_cmp_hi) begin
            mtimecmp[2*xlen-1:xlen] <= merge_bytes(mtimecmp[2*xlen-1:xlen], wdata, mask);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk) begin
        case (sel)
            sel_time_lo: rdata <= mtime[xlen-1:0];
            sel_time_hi: rdata <= mtime[2*xlen-1:xlen];
            sel_cmp_lo:  rdata <= mtimecmp[xlen-1:0];
            sel_cmp_hi:  rdata <= mtimecmp[2*xlen-1:xlen];
            default:     rdata <= '1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                             clk,
    input  wire                             en,
    input  wire                             we,
    input  wire  [$clog2(RAM_WORDS)-1:0]    addr,
    input  wire  [mem_pkg::xlen-1:0]        wdata,
    input  wire  [mem_pkg::mask_w-1:0]      mask,
    output logic [mem_pkg::xlen-1:0]        rdata
);

    import mem_pkg::*;

    logic [xlen-1:0] mem [RAM_WORDS];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (en && we) begin
            for (int i = 0; i < mask_w; i++) begin
                if (mask[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, old value kept between reads
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_map_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mem_map_ctrl #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                             clk,
    input  wire                             rst_n,

    input  wire                             mem_cmd_start,
    input  wire                             mem_cmd_write,
    output logic                            mem_cmd_ready,
    input  wire  [mem_pkg::xlen-1:0]        mem_addr,
    input  wire  [mem_pkg::xlen-1:0]        mem_wdata,
    input  wire  [mem_pkg::mask_w-1:0]      mem_wmask,
    output logic [mem_pkg::xlen-1:0]        mem_rdata,
    output logic                            mem_rdata_valid,

    output logic                            ram_en,
    output logic                            ram_we,
    output logic [$clog2(RAM_WORDS)-1:0]    ram_addr,
    output logic [mem_pkg::xlen-1:0]        ram_wdata,
    output logic [mem_pkg::mask_w-1:0]      ram_mask,
    input  wire  [mem_pkg::xlen-1:0]        ram_rdata,

    output logic                            tmr_we,
    output logic [1:0]                      tmr_sel,
    output logic [mem_pkg::xlen-1:0]        tmr_wdata,
    output logic [mem_pkg::mask_w-1:0]      tmr_mask,
    input  wire  [mem_pkg::xlen-1:0]        tmr_rdata
);

    import mem_pkg::*;

    localparam int aw = $clog2(RAM_WORDS);

    logic accept;
    logic ram_hit;
    logic tmr_hit;
    logic bus_up;   // ready from the first cycle after reset
    logic rd_ram;   // target of the outstanding read
    logic rd_tmr;

    assign accept  = mem_cmd_start && mem_cmd_ready;
    assign ram_hit = (mem_addr >> (aw + 2)) == '0;
    assign tmr_hit = mem_addr[xlen-1:4] == timer_base[xlen-1:4];

    // byte offset to timer register index
    always_comb begin
        case ({mem_addr[3:2], 2'b00})
            mtime_lo_off:    tmr_sel = 2'd0;
            mtime_hi_off:    tmr_sel = 2'd1;
            mtimecmp_lo_off: tmr_sel = 2'd2;
            mtimecmp_hi_off: tmr_sel = 2'd3;
            default:         tmr_sel = 2'd0;
        endcase
    end

    assign ram_en    = accept && ram_hit;
    assign ram_we    = mem_cmd_write;
    assign ram_addr  = mem_addr[aw+1:2]; // low two bits ignored
    assign ram_wdata = mem_wdata;
    assign ram_mask  = mem_wmask;

    assign tmr_we    = accept && mem_cmd_write && tmr_hit;
    assign tmr_wdata = mem_wdata;
    assign tmr_mask  = mem_wmask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_up          <= 1'b0;
            mem_rdata_valid <= 1'b0;
            rd_ram          <= 1'b0;
            rd_tmr          <= 1'b0;
        end else begin
            bus_up          <= 1'b1;
            mem_rdata_valid <= accept && !mem_cmd_write;
            rd_ram          <= accept && !mem_cmd_write && ram_hit;
            rd_tmr          <= accept && !mem_cmd_write && tmr_hit;
        end
    end

    // reads finish in one cycle so ready stays up once the bus is running
    assign mem_cmd_ready = bus_up;
    assign mem_rdata     = rd_ram ? ram_rdata : (rd_tmr ? tmr_rdata : '1); // unmapped

    a_start_ready: assert property (@(posedge clk) disable iff (!rst_n)
        mem_cmd_start |-> mem_cmd_ready)
        else $error("bus command offered while not ready");

endmodule

`default_nettype wire

// File: hw/mem_port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port_arbiter (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          inst_start,
    output logic                         inst_ready,
    input  wire  [mem_pkg::xlen-1:0]     i_addr,
    output logic [mem_pkg::xlen-1:0]     inst,
    output logic                         inst_valid,

    input  wire                          d_cmd_start,
    input  wire                          d_cmd_write,
    output logic                         d_cmd_ready,
    input  wire  [mem_pkg::xlen-1:0]     d_addr,
    input  wire  [mem_pkg::xlen-1:0]     wdata,
    input  wire  [mem_pkg::mask_w-1:0]   wmask,
    output logic [mem_pkg::xlen-1:0]     rdata,
    output logic                         rdata_valid,

    output logic                         mem_cmd_start,
    output logic                         mem_cmd_write,
    input  wire                          mem_cmd_ready,
    output logic [mem_pkg::xlen-1:0]     mem_addr,
    output logic [mem_pkg::xlen-1:0]     mem_wdata,
    output logic [mem_pkg::mask_w-1:0]   mem_wmask,
    input  wire  [mem_pkg::xlen-1:0]     mem_rdata,
    input  wire                          mem_rdata_valid
);

    import mem_pkg::*;

    arb_state_e state;
    logic is_fetch;   // current bus owner
    logic pend_d;     // saved data command not yet issued

    logic [xlen-1:0]   i_addr_q;
    logic              d_write_q;
    logic [xlen-1:0]   d_addr_q;
    logic [xlen-1:0]   wdata_q;
    logic [mask_w-1:0] wmask_q;
    logic [xlen-1:0]   inst_q;
    logic [xlen-1:0]   rdata_q;

    logic direct_write;
    logic ret_fetch;
    logic ret_data;
    logic queued_write;

    assign inst_ready  = (state == idle);
    assign d_cmd_ready = (state == idle);

    // a lone write goes straight to the bus
    assign direct_write = (state == idle) && d_cmd_start && d_cmd_write && !inst_start
                          && mem_cmd_ready;

    assign ret_fetch    = (state == wait_read) && mem_rdata_valid && is_fetch;
    assign ret_data     = (state == wait_read) && mem_rdata_valid && !is_fetch;
    assign queued_write = ret_fetch && pend_d && d_write_q && mem_cmd_ready;

    assign inst_valid  = ret_fetch;
    assign rdata_valid = ret_data;
    assign inst        = ret_fetch ? mem_rdata : inst_q;
    assign rdata       = ret_data ? mem_rdata : rdata_q;

    always_comb begin
        mem_cmd_start = 1'b0;
        mem_cmd_write = 1'b0;
        mem_addr      = d_addr_q;
        case (state)
            idle: begin
                mem_cmd_start = direct_write;
                mem_cmd_write = d_cmd_write;
                mem_addr      = d_addr;
            end
            wait_ready: begin
                mem_cmd_start = mem_cmd_ready;
                mem_cmd_write = !is_fetch && d_write_q;
                mem_addr      = is_fetch ? i_addr_q : d_addr_q;
            end
            wait_read: begin
                mem_cmd_start = queued_write; // store behind a fetch
                mem_cmd_write = 1'b1;
            end
            default: begin
                mem_cmd_start = 1'b0;
            end
        endcase
    end

    assign mem_wdata = (state == idle) ? wdata : wdata_q;
    assign mem_wmask = (state == idle) ? wmask : wmask_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            is_fetch <= 1'b0;
            pend_d   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (inst_start) begin
                        is_fetch <= 1'b1;
                        pend_d   <= d_cmd_start; // fetch wins, data waits
                        state    <= wait_ready;
                    end else if (d_cmd_start) begin
                        is_fetch <= 1'b0;
                        if (!direct_write) begin
                            pend_d <= 1'b1;
                            state  <= wait_ready;
                        end
                    end
                end
                wait_ready: begin
                    if (mem_cmd_ready) begin
                        if (!is_fetch) begin
                            pend_d <= 1'b0;
                        end
                        if (is_fetch || !d_write_q) begin
                            state <= wait_read;
                        end else begin
                            state <= idle;
                        end
                    end
                end
                wait_read: begin
                    if (mem_rdata_valid) begin
                        if (is_fetch && pend_d) begin
                            is_fetch <= 1'b0;
                            if (queued_write) begin
                                pend_d <= 1'b0;
                                state  <= idle;
                            end else begin
                                state <= wait_ready; // queued read or bus busy
                            end
                        end else begin
                            state <= idle;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && inst_start) begin
            i_addr_q <= i_addr;
        end
        if (state == idle && d_cmd_start) begin
            d_write_q <= d_cmd_write;
            d_addr_q  <= d_addr;
            wdata_q   <= wdata;
            wmask_q   <= wmask;
        end
        if (ret_fetch) begin
            inst_q <= mem_rdata;
        end
        if (ret_data) begin
            rdata_q <= mem_rdata;
        end
    end

    // the bus only answers reads the arbiter is waiting for
    a_no_ret_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle) |-> !mem_rdata_valid)
        else $error("read data returned while arbiter idle");

    // fetch latency through arbiter and map controller
    a_fetch_lat: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_start && inst_ready) |-> ##2 (inst_valid && !rdata_valid))
        else $error("fetch not answered two cycles after acceptance");

endmodule

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

    parameter int xlen   = 32;
    parameter int mask_w = xlen / 8;

    // address map
    parameter logic [xlen-1:0] timer_base = 32'h0000_8000;

    parameter logic [3:0] mtime_lo_off    = 4'h0;
    parameter logic [3:0] mtime_hi_off    = 4'h4;
    parameter logic [3:0] mtimecmp_lo_off = 4'h8;
    parameter logic [3:0] mtimecmp_hi_off = 4'hc;

    typedef enum logic [1:0] {
        idle       = 2'd0,
        wait_ready = 2'd1,
        wait_read  = 2'd2
    } arb_state_e;

    // replace the byte lanes of old_w that are set in m
    function automatic logic [xlen-1:0] merge_bytes(
        input logic [xlen-1:0]   old_w,
        input logic [xlen-1:0]   new_w,
        input logic [mask_w-1:0] m
    );
        logic [xlen-1:0] res;
        res = old_w;
        for (int i = 0; i < mask_w; i++) begin
            if (m[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire
